// File: hdl/ioBusPkg.sv
package ioBusPkg;

  // ============================================================
  // Bus widths
  // ============================================================
  localparam int dataWidth = 32;
  localparam int addrWidth = 32;

  // Byte distance between neighbouring registers of one device
  localparam logic [addrWidth-1:0] regStride = 32'd4;

  // ============================================================
  // Memory map, one base word per device
  // ============================================================
  localparam logic [addrWidth-1:0] addrHex   = 32'hFFFFF000;
  localparam logic [addrWidth-1:0] addrLedr  = 32'hFFFFF020;
  localparam logic [addrWidth-1:0] addrKey   = 32'hFFFFF080;
  localparam logic [addrWidth-1:0] addrSw    = 32'hFFFFF090;
  localparam logic [addrWidth-1:0] addrTimer = 32'hFFFFF100;

  // Request presented to every device on each clock
  typedef struct packed {
    logic [addrWidth-1:0] addr;
    logic [dataWidth-1:0] wData;
    logic                 we;
  } busReq_t;

endpackage

// File: hdl/ioDevPkg.sv
package ioDevPkg;

  // ============================================================
  // Control register layout, shared by keys, switches and timer
  // ============================================================
  localparam int ctlReadyBit   = 0;
  localparam int ctlOverrunBit = 1;
  localparam int ctlIntEnBit   = 4;

  typedef struct packed {
    logic intEn;
    logic overrun;
    logic ready;
  } ctlReg_t;

  // Pins are looked at once per this many clocks
  localparam int debounceTicks = 16;

  localparam int keyWidth  = 4;
  localparam int swWidth   = 10;
  localparam int ledrWidth = 10;
  localparam int hexDigits = 6;
  localparam int hexWidth  = 4 * hexDigits;

  typedef logic [keyWidth-1:0] keyBits_t;
  typedef logic [swWidth-1:0]  swBits_t;

  // ============================================================
  // Seven-segment display, segments are active low
  // ============================================================
  typedef logic [3:0] hexDigit_t;
  typedef logic [6:0] segCode_t;
  typedef segCode_t [hexDigits-1:0] hexSegs_t;

  localparam segCode_t [0:15] segTable = '{
    7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
    7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
    7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
    7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
  };

  localparam logic [hexWidth-1:0] hexResetValue = 24'hFEDEAD;

  // Interrupt ids, lower id wins
  localparam logic [3:0] irqTimer = 4'd1;
  localparam logic [3:0] irqKey   = 4'd2;
  localparam logic [3:0] irqSw    = 4'd3;
  localparam logic [3:0] irqNone  = 4'd15;

  // Control register as seen on the bus
  function automatic logic [ioBusPkg::dataWidth-1:0] ctlWord(ctlReg_t ctl);
    logic [ioBusPkg::dataWidth-1:0] word;
    word = '0;
    word[ctlReadyBit]   = ctl.ready;
    word[ctlOverrunBit] = ctl.overrun;
    word[ctlIntEnBit]   = ctl.intEn;
    return word;
  endfunction

  // Bus write: zero in bit 0 or 1 clears that flag, bit 4 loads the enable
  function automatic ctlReg_t ctlWritten(ctlReg_t cur, logic [ioBusPkg::dataWidth-1:0] w);
    ctlReg_t upd;
    upd = cur;
    if (!w[ctlReadyBit])
      upd.ready = 1'b0;
    if (!w[ctlOverrunBit])
      upd.overrun = 1'b0;
    upd.intEn = w[ctlIntEnBit];
    return upd;
  endfunction

endpackage

// File: hdl/debouncedPort.sv
module debouncedPort #(
  parameter type payload_t = ioDevPkg::keyBits_t,
  parameter logic [ioBusPkg::addrWidth-1:0] baseAddr = ioBusPkg::addrKey
) (
  input  logic                            clk,
  input  logic                            RESET,
  input  ioBusPkg::busReq_t               busReq,
  input  payload_t                        pins,
  output logic [ioBusPkg::dataWidth-1:0]  rData,
  output logic                            irq
);

  localparam int payloadWidth = $bits(payload_t);
  localparam int tickWidth = $clog2(ioDevPkg::debounceTicks);

  logic [tickWidth-1:0] tickCnt;
  logic                 tick;
  payload_t             sample;
  payload_t             lastSample;
  payload_t             dataReg;
  ioDevPkg::ctlReg_t    ctl;
  ioDevPkg::ctlReg_t    ctlNext;
  logic                 selData;
  logic                 selCtl;
  logic                 rdData;
  logic                 wrCtl;
  logic                 change;

  assign selData = (busReq.addr == baseAddr);
  assign selCtl  = (busReq.addr == baseAddr + ioBusPkg::regStride);
  assign rdData  = selData && !busReq.we;
  assign wrCtl   = selCtl && busReq.we;

  assign tick = (tickCnt == tickWidth'(ioDevPkg::debounceTicks - 1));

  // Two equal samples that differ from the held value count as a change
  assign change = tick && (sample == lastSample) && (sample != dataReg);

  // ============================================================
  // Control flags
  // ============================================================
  always_comb begin
    ctlNext = ctl;
    // Reading the data register acknowledges it
    if (rdData)
      ctlNext.ready = 1'b0;
    if (wrCtl)
      ctlNext = ioDevPkg::ctlWritten(ctlNext, busReq.wData);
    if (change) begin
      if (ctlNext.ready)
        ctlNext.overrun = 1'b1;
      else
        ctlNext.ready = 1'b1;
    end
  end

  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      tickCnt    <= '0;
      sample     <= '0;
      lastSample <= '0;
      dataReg    <= '0;
      ctl        <= '0;
    end else begin
      tickCnt <= tick ? '0 : tickCnt + 1'b1;
      if (tick) begin
        sample     <= pins;
        lastSample <= sample;
      end
      if (change)
        dataReg <= sample;
      ctl <= ctlNext;
    end
  end

  always_comb begin
    if (selData)
      rData = {{(ioBusPkg::dataWidth - payloadWidth){1'b0}}, dataReg};
    else if (selCtl)
      rData = ioDevPkg::ctlWord(ctl);
    else
      rData = '0;
  end

  assign irq = ctl.ready && ctl.intEn;

endmodule

// File: hdl/intervalTimer.sv
module intervalTimer #(
  parameter logic [ioBusPkg::addrWidth-1:0] baseAddr = ioBusPkg::addrTimer
) (
  input  logic                            clk,
  input  logic                            RESET,
  input  ioBusPkg::busReq_t               busReq,
  output logic [ioBusPkg::dataWidth-1:0]  rData,
  output logic                            irq
);

  logic [ioBusPkg::dataWidth-1:0] count;
  logic [ioBusPkg::dataWidth-1:0] limit;
  ioDevPkg::ctlReg_t              ctl;
  ioDevPkg::ctlReg_t              ctlNext;
  logic                           selCnt;
  logic                           selLim;
  logic                           selCtl;
  logic                           wrap;

  assign selCnt = (busReq.addr == baseAddr);
  assign selLim = (busReq.addr == baseAddr + ioBusPkg::regStride);
  assign selCtl = (busReq.addr == baseAddr + 2 * ioBusPkg::regStride);

  // A zero limit leaves the counter free running without events
  assign wrap = (limit != '0) && (count >= limit);

  // ============================================================
  // Control flags
  // ============================================================
  always_comb begin
    ctlNext = ctl;
    if (selCtl && busReq.we)
      ctlNext = ioDevPkg::ctlWritten(ctlNext, busReq.wData);
    if (wrap) begin
      if (ctlNext.ready)
        ctlNext.overrun = 1'b1;
      else
        ctlNext.ready = 1'b1;
    end
  end

  // ============================================================
  // Count and limit
  // ============================================================
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      count <= '0;
      limit <= '0;
      ctl   <= '0;
    end else begin
      // Bus loads take priority over the wrap and the increment
      if (busReq.we && selCnt) begin
        count <= busReq.wData;
      end else if (busReq.we && selLim) begin
        count <= '0;
      end else if (wrap) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
      if (busReq.we && selLim)
        limit <= busReq.wData;
      ctl <= ctlNext;
    end
  end

  always_comb begin
    if (selCnt)
      rData = count;
    else if (selLim)
      rData = limit;
    else if (selCtl)
      rData = ioDevPkg::ctlWord(ctl);
    else
      rData = '0;
  end

  assign irq = ctl.ready && ctl.intEn;

endmodule

// File: hdl/displayPort.sv
module displayPort (
  input  logic                              clk,
  input  logic                              RESET,
  input  ioBusPkg::busReq_t                 busReq,
  output logic [ioBusPkg::dataWidth-1:0]    rData,
  output logic [ioDevPkg::ledrWidth-1:0]    ledr,
  output ioDevPkg::hexSegs_t                hexSegs
);

  logic [ioDevPkg::ledrWidth-1:0]                    ledrReg;
  ioDevPkg::hexDigit_t [ioDevPkg::hexDigits-1:0]     hexReg;
  logic                                              selLedr;
  logic                                              selHex;

  assign selLedr = (busReq.addr == ioBusPkg::addrLedr);
  assign selHex  = (busReq.addr == ioBusPkg::addrHex);

  // ============================================================
  // Output registers
  // ============================================================
  always_ff @(posedge clk or posedge RESET) begin
    if (RESET) begin
      ledrReg <= '0;
      hexReg  <= ioDevPkg::hexResetValue;
    end else begin
      if (busReq.we && selLedr)
        ledrReg <= busReq.wData[ioDevPkg::ledrWidth-1:0];
      if (busReq.we && selHex)
        hexReg <= busReq.wData[ioDevPkg::hexWidth-1:0];
    end
  end

  always_comb begin
    if (selLedr)
      rData = {{(ioBusPkg::dataWidth - ioDevPkg::ledrWidth){1'b0}}, ledrReg};
    else if (selHex)
      rData = {{(ioBusPkg::dataWidth - ioDevPkg::hexWidth){1'b0}}, hexReg};
    else
      rData = '0;
  end

  assign ledr = ledrReg;

  // Digit 5 shows the top nibble, digit 0 the bottom one
  always_comb begin
    for (int i = 0; i < ioDevPkg::hexDigits; i++) begin
      hexSegs[i] = ioDevPkg::segTable[hexReg[i]];
    end
  end

endmodule

// File: hdl/ioSystem.sv
module ioSystem (
  input  logic                              clk,
  input  logic                              RESET,
  input  ioBusPkg::busReq_t                 busReq,
  input  ioDevPkg::keyBits_t                key,
  input  ioDevPkg::swBits_t                 sw,
  output logic [ioBusPkg::dataWidth-1:0]    rData,
  output logic                              irq,
  output logic [3:0]                        irqId,
  output logic [ioDevPkg::ledrWidth-1:0]    ledr,
  output ioDevPkg::hexSegs_t                hexSegs
);

  logic [ioBusPkg::dataWidth-1:0] keyRData;
  logic [ioBusPkg::dataWidth-1:0] swRData;
  logic [ioBusPkg::dataWidth-1:0] timerRData;
  logic [ioBusPkg::dataWidth-1:0] dispRData;
  logic                           keyIrq;
  logic                           swIrq;
  logic                           timerIrq;

  // ============================================================
  // Devices
  // ============================================================
  debouncedPort #(
    .payload_t (ioDevPkg::keyBits_t),
    .baseAddr  (ioBusPkg::addrKey)
  ) keyPort (
    .clk    (clk),
    .RESET  (RESET),
    .busReq (busReq),
    .pins   (key),
    .rData  (keyRData),
    .irq    (keyIrq)
  );

  debouncedPort #(
    .payload_t (ioDevPkg::swBits_t),
    .baseAddr  (ioBusPkg::addrSw)
  ) swPort (
    .clk    (clk),
    .RESET  (RESET),
    .busReq (busReq),
    .pins   (sw),
    .rData  (swRData),
    .irq    (swIrq)
  );

  intervalTimer #(
    .baseAddr (ioBusPkg::addrTimer)
  ) timer (
    .clk    (clk),
    .RESET  (RESET),
    .busReq (busReq),
    .rData  (timerRData),
    .irq    (timerIrq)
  );

  displayPort display (
    .clk     (clk),
    .RESET   (RESET),
    .busReq  (busReq),
    .rData   (dispRData),
    .ledr    (ledr),
    .hexSegs (hexSegs)
  );

  // Unselected devices return zero, so OR is enough
  assign rData = keyRData | swRData | timerRData | dispRData;

  // ============================================================
  // Interrupt priority
  // ============================================================
  assign irq = timerIrq || keyIrq || swIrq;

  always_comb begin
    if (timerIrq)
      irqId = ioDevPkg::irqTimer;
    else if (keyIrq)
      irqId = ioDevPkg::irqKey;
    else if (swIrq)
      irqId = ioDevPkg::irqSw;
    else
      irqId = ioDevPkg::irqNone;
  end

endmodule

// File: tb/ioChecker.sv
module ioChecker (clk, RESET, busReq, rData, irq, irqId, ledr, hexSegs, chkExp, errorCount);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int nameChars = 24;

  typedef struct packed {
    logic                   checkRead;
    logic [31:0]            expData;
    logic [31:0]            expMask;
    logic                   checkIrq;
    logic [3:0]             expIrqId;
    logic                   testEnd;
    logic [8*nameChars-1:0] testName;
    logic                   runDone;
  } expect_t;

  input  logic                           clk;
  input  logic                           RESET;
  input  ioBusPkg::busReq_t              busReq;
  input  logic [ioBusPkg::dataWidth-1:0] rData;
  input  logic                           irq;
  input  logic [3:0]                     irqId;
  input  logic [ioDevPkg::ledrWidth-1:0] ledr;
  input  ioDevPkg::hexSegs_t             hexSegs;
  input  expect_t                        chkExp;
  output int                             errorCount;

  logic [ioDevPkg::ledrWidth-1:0] modelLedr;
  logic [23:0]                    modelHex;
  int                             checks;
  int                             testErrors;
  int                             testsRun;
  int                             testsFailed;

  initial begin
    errorCount = 0;
    checks = 0;
    testErrors = 0;
    testsRun = 0;
    testsFailed = 0;
  end

  // Active-low segments gfedcba for one hex digit
  function automatic logic [6:0] segFor(logic [3:0] nibble);
    case (nibble)
      4'h0: segFor = 7'b1000000;
      4'h1: segFor = 7'b1111001;
      4'h2: segFor = 7'b0100100;
      4'h3: segFor = 7'b0110000;
      4'h4: segFor = 7'b0011001;
      4'h5: segFor = 7'b0010010;
      4'h6: segFor = 7'b0000010;
      4'h7: segFor = 7'b1111000;
      4'h8: segFor = 7'b0000000;
      4'h9: segFor = 7'b0010000;
      4'hA: segFor = 7'b0001000;
      4'hB: segFor = 7'b0000011;
      4'hC: segFor = 7'b1000110;
      4'hD: segFor = 7'b0100001;
      4'hE: segFor = 7'b0000110;
      default: segFor = 7'b0001110;
    endcase
  endfunction

  function automatic ioDevPkg::hexSegs_t segsFor(logic [23:0] value);
    ioDevPkg::hexSegs_t s;
    for (int d = 0; d < ioDevPkg::hexDigits; d++)
      s[d] = segFor(value[4*d +: 4]);
    return s;
  endfunction

  task automatic reportMismatch(string msg);
    $display("CHECK FAILED at %0d ns: %s", $time, msg);
    errorCount++;
    testErrors++;
  endtask

  // ============================================================
  // Sampled on the rising edge, before the DUT registers update
  // ============================================================
  always @(posedge clk) begin
    if (RESET) begin
      modelLedr = '0;
      modelHex = ioDevPkg::hexResetValue;
    end else begin
      checks++;
      if (ledr !== modelLedr)
        reportMismatch($sformatf("ledr is %h, expected %h", ledr, modelLedr));
      if (hexSegs !== segsFor(modelHex))
        reportMismatch($sformatf("hexSegs is %h, expected %h for value %h",
                                 hexSegs, segsFor(modelHex), modelHex));
      if (chkExp.checkRead && ((rData & chkExp.expMask) !== (chkExp.expData & chkExp.expMask)))
        reportMismatch($sformatf("read of %h gave %h, expected %h under mask %h",
                                 busReq.addr, rData, chkExp.expData, chkExp.expMask));
      if (chkExp.checkIrq) begin
        if (irqId !== chkExp.expIrqId)
          reportMismatch($sformatf("irqId is %0d, expected %0d", irqId, chkExp.expIrqId));
        if (irq !== (chkExp.expIrqId != ioDevPkg::irqNone))
          reportMismatch($sformatf("irq is %b with expected id %0d", irq, chkExp.expIrqId));
      end
      // Display registers take the write at this edge
      if (busReq.we && busReq.addr == ioBusPkg::addrLedr)
        modelLedr = busReq.wData[ioDevPkg::ledrWidth-1:0];
      if (busReq.we && busReq.addr == ioBusPkg::addrHex)
        modelHex = busReq.wData[23:0];
      if (chkExp.testEnd) begin
        testsRun++;
        if (testErrors == 0) begin
          $display("test %0s: ok", chkExp.testName);
        end else begin
          testsFailed++;
          $display("test %0s: %0d errors", chkExp.testName, testErrors);
        end
        testErrors = 0;
      end
      if (chkExp.runDone)
        $display("Summary: %0d tests, %0d failing, %0d cycles checked, %0d errors",
                 testsRun, testsFailed, checks, errorCount);
    end
  end

endmodule

// File: tb/ioSystemTb.sv
module ioSystemTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clkPeriod    = 4;
  localparam int resetCycles  = 8;
  localparam int marginCycles = 200;
  localparam int maxJitter    = 2;
  localparam int nameChars    = 24;
  localparam logic [31:0] seed = 32'h6bb45bfa;

  // Expected values handed to the checker for the current cycle
  typedef struct packed {
    logic                   checkRead;
    logic [31:0]            expData;
    logic [31:0]            expMask;
    logic                   checkIrq;
    logic [3:0]             expIrqId;
    logic                   testEnd;
    logic [8*nameChars-1:0] testName;
    logic                   runDone;
  } expect_t;

  logic                           clk;
  logic                           RESET;
  ioBusPkg::busReq_t              busReq;
  ioDevPkg::keyBits_t             key;
  ioDevPkg::swBits_t              sw;
  logic [ioBusPkg::dataWidth-1:0] rData;
  logic                           irq;
  logic [3:0]                     irqId;
  logic [ioDevPkg::ledrWidth-1:0] ledr;
  ioDevPkg::hexSegs_t             hexSegs;
  expect_t                        chkExp;
  int                             errorCount;
  int                             vectorErrors;
  int                             budgetCycles;
  logic [31:0]                    lastRandom;

  // One entry per vector line
  string                  opList[$];
  logic [31:0]            argA[$];
  logic [31:0]            argB[$];
  logic [31:0]            argC[$];
  bit                     anyList[$];
  logic [8*nameChars-1:0] nameList[$];

  ioSystem u_ioSystem (
    .clk     (clk),
    .RESET   (RESET),
    .busReq  (busReq),
    .key     (key),
    .sw      (sw),
    .rData   (rData),
    .irq     (irq),
    .irqId   (irqId),
    .ledr    (ledr),
    .hexSegs (hexSegs)
  );

  ioChecker respCheck (
    .clk        (clk),
    .RESET      (RESET),
    .busReq     (busReq),
    .rData      (rData),
    .irq        (irq),
    .irqId      (irqId),
    .ledr       (ledr),
    .hexSegs    (hexSegs),
    .chkExp     (chkExp),
    .errorCount (errorCount)
  );

  always #(clkPeriod / 2) clk = ~clk;

  // ============================================================
  // Vector file
  // ============================================================
  task automatic readVectors();
    int                     fd;
    int                     n;
    string                  line;
    string                  op;
    string                  tok;
    logic [31:0]            a;
    logic [31:0]            b;
    logic [31:0]            c;
    logic [8*nameChars-1:0] nm;
    fd = $fopen("tb/ioVectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tb/ioVectors.txt");
      vectorErrors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n <= 1 || line.substr(0, 0) == "#")
        continue;
      a = '0;
      b = '0;
      c = '0;
      tok = "";
      nm = '0;
      n = $sscanf(line, "%s", op);
      case (op)
        "W": n = $sscanf(line, "%s %h %s", op, a, tok);
        "R": n = $sscanf(line, "%s %h %s %h", op, a, tok, c);
        "P": n = $sscanf(line, "%s %h %h", op, a, b);
        "D", "I": n = $sscanf(line, "%s %d", op, a);
        "E": n = $sscanf(line, "%s %s", op, nm);
        default: begin
          $display("Vector line with unknown operation: %s", line);
          vectorErrors++;
        end
      endcase
      if (tok != "" && tok != "any")
        n = $sscanf(tok, "%h", b);
      opList.push_back(op);
      argA.push_back(a);
      argB.push_back(b);
      argC.push_back(c);
      anyList.push_back(tok == "any");
      nameList.push_back(nm);
    end
    $fclose(fd);
  endtask

  // ============================================================
  // Bus stimulus applied on the falling edge
  // ============================================================
  task automatic driveCycle(ioBusPkg::busReq_t req, expect_t e);
    @(negedge clk);
    busReq = req;
    chkExp = e;
  endtask

  // Address 0 is unmapped, so an idle bus selects nothing
  task automatic idle(int cycles);
    repeat (cycles) driveCycle('0, '0);
  endtask

  task automatic runOp(int i);
    ioBusPkg::busReq_t req;
    expect_t           e;
    req = '0;
    e = '0;
    case (opList[i])
      "W": begin
        req.addr = argA[i];
        req.wData = argB[i];
        if (anyList[i]) begin
          lastRandom = $urandom;
          req.wData = lastRandom;
        end
        req.we = 1'b1;
        driveCycle(req, e);
        idle($urandom_range(maxJitter, 0));
      end
      "R": begin
        req.addr = argA[i];
        e.checkRead = 1'b1;
        e.expData = anyList[i] ? lastRandom : argB[i];
        e.expMask = argC[i];
        driveCycle(req, e);
        idle($urandom_range(maxJitter, 0));
      end
      "P": begin
        @(negedge clk);
        key = argA[i][ioDevPkg::keyWidth-1:0];
        sw = argB[i][ioDevPkg::swWidth-1:0];
        busReq = '0;
        chkExp = '0;
      end
      "D": idle(argA[i]);
      "I": begin
        e.checkIrq = 1'b1;
        e.expIrqId = argA[i][3:0];
        driveCycle(req, e);
      end
      "E": begin
        e.testEnd = 1'b1;
        e.testName = nameList[i];
        driveCycle(req, e);
      end
      default: ;
    endcase
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial begin
    logic [31:0] seedDummy;
    expect_t     doneExp;
    seedDummy = $urandom(seed);
    clk = 1'b0;
    RESET = 1'b1;
    busReq = '0;
    key = '0;
    sw = '0;
    chkExp = '0;
    vectorErrors = 0;
    lastRandom = '0;
    readVectors();
    budgetCycles = resetCycles + marginCycles;
    foreach (opList[i])
      budgetCycles += (opList[i] == "D") ? int'(argA[i]) : 1 + maxJitter;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    RESET = 1'b0;
    if (vectorErrors == 0) begin
      foreach (opList[i])
        runOp(i);
    end
    idle(1);
    doneExp = '0;
    doneExp.runDone = 1'b1;
    driveCycle('0, doneExp);
    idle(1);
    if (errorCount == 0 && vectorErrors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // Watchdog sized from the vectors once they are read
  initial begin
    wait (budgetCycles > 0);
    #(budgetCycles * clkPeriod);
    $display("Run did not finish within %0d cycles and was stopped", budgetCycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: tb/ioVectors.txt
# W addr data|any ; R addr expected|any mask ; P key sw ; D cycles ; I irqId ; E name
# Hex fields except D and I, which are decimal. "any" uses the last random write
R FFFFF020 00000000 FFFFFFFF
R FFFFF000 00FEDEAD FFFFFFFF
R FFFFF084 00000000 FFFFFFFF
R FFFFF094 00000000 FFFFFFFF
R FFFFF108 00000000 FFFFFFFF
I 15
E resetValues
W FFFFF020 000002A5
R FFFFF020 000002A5 FFFFFFFF
W FFFFF000 00123456
R FFFFF000 00123456 FFFFFFFF
W FFFFF000 any
R FFFFF000 any 00FFFFFF
W FFFFF020 any
R FFFFF020 any 000003FF
W FFFFF000 0089ABCD
R FFFFF000 0089ABCD FFFFFFFF
E ledAndHex
P 5 000
D 64
R FFFFF084 00000001 00000003
P A 000
D 64
R FFFFF084 00000003 00000003
R FFFFF080 0000000A FFFFFFFF
R FFFFF084 00000002 00000003
W FFFFF084 00000001
R FFFFF084 00000000 FFFFFFFF
P A 2B5
D 64
R FFFFF094 00000001 00000003
R FFFFF090 000002B5 FFFFFFFF
R FFFFF094 00000000 00000003
E keyAndSwitch
W FFFFF104 00000014
D 40
R FFFFF108 00000001 00000001
D 40
R FFFFF108 00000003 00000003
W FFFFF100 00000010
R FFFFF100 00000010 FFFFFFFC
W FFFFF104 00000000
W FFFFF108 00000000
R FFFFF108 00000000 FFFFFFFF
E timer
W FFFFF084 00000010
W FFFFF104 00000014
W FFFFF108 00000010
P 3 2B5
D 64
I 1
W FFFFF104 00000000
W FFFFF108 00000010
I 2
R FFFFF080 00000003 FFFFFFFF
W FFFFF084 00000000
W FFFFF108 00000000
I 15
E interrupts

// File: sources.f
hdl/ioBusPkg.sv
hdl/ioDevPkg.sv
hdl/debouncedPort.sv
hdl/intervalTimer.sv
hdl/displayPort.sv
hdl/ioSystem.sv
tb/ioChecker.sv
tb/ioSystemTb.sv

// File: Bender.yml
package:
  name: io_system

sources:
  - hdl/ioBusPkg.sv
  - hdl/ioDevPkg.sv
  - hdl/debouncedPort.sv
  - hdl/intervalTimer.sv
  - hdl/displayPort.sv
  - hdl/ioSystem.sv
  - target: simulation
    files:
      - tb/ioChecker.sv
      - tb/ioSystemTb.sv
